//--- tb.f
+incdir+.
rcb_pkg.sv
rcb_addr_decode.sv
rcb_input_sync.sv
rcb_estop_sticky.sv
rcb_control_regs.sv
rcb_estop_pulse.sv
rcb_read_mux.sv
rcb_registers.sv
tb_rcb_registers.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_rcb_registers
RTL_TOP    = rcb_registers
FILELIST   = tb.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_rcb_registers.sv
/*
 * Directed testbench for the RCB register block. Drives SPI-side
 * strobes and raw inputs, checks read-back words and output pins.
 */
`include "rcb_params.svh"

module tb_rcb_registers
	import rcb_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT  = 20;
	// 200 ns slow clock period in 10 ns cycles
	localparam int SLOW_CYCLES = 20;
	localparam int PULSE_TICKS = int'(`RCB_ESTOP_PULSE_TICKS);

	logic       clk_100m;
	logic       rst_n_syn;
	logic       clk_100k;
	reg_addr_t  addr;
	reg_word_t  data_mosi;
	logic       data_mosi_rdy;
	logic       data_miso_rdy;
	reg_word_t  data_miso;
	led_byte_t  fpga_buttons;
	logic [3:0] wheel_driver_do;
	logic       estop_btn1_nc;
	logic       estop_btn1_no;
	logic       estop_btn2_nc;
	logic       estop_btn2_no;
	logic [3:0] wheel_home_sw;
	logic [3:0] wheel_reverse_sw;
	logic [3:0] wheel_forward_sw;
	led_byte_t  wheel_driver_di;
	logic       wheel_driver_elo;
	logic       wheel_driver_rst;
	logic       wheel_driver_abrt;
	reg_word_t  fpga_buttons_led_reg;
	logic       estop_activation;
	logic       diag_activation;
	logic       estop_open;
	led_byte_t  diagnostic_led;

	logic [31:0] lcg_state = 32'h60c5_51df;

	rcb_registers rcb_registers_inst (.*);

	always #5 clk_100m = ~clk_100m;
	always #100 clk_100k = ~clk_100k;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// All tasks start and end 1 ns after a rising edge
	task automatic write_reg(input reg_addr_t a, input reg_word_t d);
		addr          = a;
		data_mosi     = d;
		data_mosi_rdy = 1'b1;
		@(posedge clk_100m);
		#1;
		data_mosi_rdy = 1'b0;
	endtask

	task automatic read_check(input reg_addr_t a, input reg_word_t expected,
		input string name);
		addr = a;
		#4;
		check_value(name, data_miso, expected);
		@(posedge clk_100m);
		#1;
	endtask

	// Status read taken by the SPI slave, releases held flags
	task automatic status_ack(input reg_word_t expected);
		addr          = `RCB_ADDR_ESTOP_STATUS;
		data_miso_rdy = 1'b1;
		#4;
		check_value("estop_status", data_miso, expected);
		@(posedge clk_100m);
		#1;
		data_miso_rdy = 1'b0;
	endtask

	task automatic wait_read(input reg_addr_t a, input reg_word_t value, input string what);
		int n;
		bit seen;
		seen = 1'b0;
		addr = a;
		for (n = 0; n < WAIT_LIMIT && !seen; n++)
		begin
			#4;
			if (data_miso == value)
				seen = 1'b1;
			@(posedge clk_100m);
			#1;
		end
		if (!seen)
		begin
			$display("Checks failed");
			$fatal(1, "timeout waiting for %s to read 0x%h", what, value);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_identity();
		read_check(`RCB_ADDR_VER, {16'h0, `RCB_FPGA_MAJOR_VER, `RCB_FPGA_REV}, "version");
		read_check(`RCB_ADDR_REV_DATA, {`RCB_REV_YEAR, `RCB_REV_MONTH, `RCB_REV_DAY,
			`RCB_REV_HOUR}, "rev_date");
		read_check(`RCB_ADDR_DIAG_LEDS, 32'h0000_00FF, "diag_leds");
		check_value("diagnostic_led", {24'h0, diagnostic_led}, 32'h0000_00FF);
		check_value("estop_activation", {31'h0, estop_activation}, 32'h1);
		read_check(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0011, "estop_status");
		read_check(16'h0100, 32'hFFFF_FFFF, "unmapped");
	endtask

	task automatic masked_writes();
		int i;
		reg_word_t w;
		for (i = 0; i < 3; i++)
		begin
			w = lcg_next();
			write_reg(`RCB_ADDR_WHEEL_OUT, w);
			check_value("wheel_home_sw", {28'h0, wheel_home_sw}, {28'h0, w[19:16]});
			check_value("wheel_reverse_sw", {28'h0, wheel_reverse_sw}, {28'h0, w[15:12]});
			check_value("wheel_forward_sw", {28'h0, wheel_forward_sw}, {28'h0, w[11:8]});
			check_value("wheel_driver_di", {24'h0, wheel_driver_di}, {24'h0, w[7:0]});
			read_check(`RCB_ADDR_WHEEL_OUT, w & 32'h000F_FFFF, "wheel_out");

			w = lcg_next();
			write_reg(`RCB_ADDR_WHEEL_ABRT, w);
			check_value("wheel_driver_rst", {31'h0, wheel_driver_rst}, {31'h0, w[1]});
			check_value("wheel_driver_abrt", {31'h0, wheel_driver_abrt}, {31'h0, w[0]});
			read_check(`RCB_ADDR_WHEEL_ABRT, w & 32'h0000_0003, "wheel_abrt");

			w = lcg_next();
			write_reg(`RCB_ADDR_WHEEL_ELO, w);
			check_value("wheel_driver_elo", {31'h0, wheel_driver_elo}, {31'h0, w[0]});
			read_check(`RCB_ADDR_WHEEL_ELO, w & 32'h0000_0001, "wheel_elo");

			// LED nibbles keep their low three bits only
			w = lcg_next();
			write_reg(`RCB_ADDR_BUTTONS_LED, w);
			check_value("fpga_buttons_led_reg", fpga_buttons_led_reg, w & 32'h0000_7777);
			read_check(`RCB_ADDR_BUTTONS_LED, w & 32'h0000_7777, "buttons_led");

			w = lcg_next();
			write_reg(`RCB_ADDR_DIAG_LEDS, w);
			check_value("diagnostic_led", {24'h0, diagnostic_led}, {24'h0, w[7:0]});
			read_check(`RCB_ADDR_DIAG_LEDS, w & 32'h0000_00FF, "diag_leds");
		end
	endtask

	task automatic input_sync_path();
		int i;
		reg_word_t r;
		for (i = 0; i < 2; i++)
		begin
			r = lcg_next();
			fpga_buttons    = r[7:0];
			wheel_driver_do = r[11:8];
			wait_read(`RCB_ADDR_BUTTONS, {24'h0, r[7:0]}, "buttons");
			wait_read(`RCB_ADDR_WHEEL_IN, {28'h0, r[11:8]}, "wheel_in");
		end
	endtask

	task automatic sticky_flags();
		// Button 1 NO drops and returns, flag bit 2 holds
		estop_btn1_no = 1'b0;
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0014, "btn1 NO drop");
		estop_btn1_no = 1'b1;
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0015, "btn1 NO restore");
		read_check(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0015, "estop_status");
		status_ack(32'h0000_0015);
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0011, "btn1 NO flag clear");

		// Contact held open across the read keeps the flag
		estop_btn1_no = 1'b0;
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0014, "btn1 NO held");
		status_ack(32'h0000_0014);
		repeat (3) read_check(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0014, "estop_status");
		estop_btn1_no = 1'b1;
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0011, "btn1 NO release");

		// Button 2 NC, synced bit 5 and flag bit 7
		estop_btn2_nc = 1'b1;
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_00B1, "btn2 NC rise");
		estop_btn2_nc = 1'b0;
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0091, "btn2 NC restore");
		status_ack(32'h0000_0091);
		wait_read(`RCB_ADDR_ESTOP_STATUS, 32'h0000_0011, "btn2 NC flag clear");
	endtask

	task automatic activation_pulse();
		int low_cycles;
		write_reg(`RCB_ADDR_ESTOP_ACTIVATION, 32'h8000_0001);
		@(posedge clk_100m);
		#1;
		check_value("estop_activation", {31'h0, estop_activation}, 32'h0);
		low_cycles = 1;
		while (!estop_activation && low_cycles < 2 * PULSE_TICKS * SLOW_CYCLES)
		begin
			@(posedge clk_100m);
			#1;
			low_cycles++;
		end
		if (!estop_activation)
		begin
			$display("Checks failed");
			$fatal(1, "estop_activation did not return high");
		end
		if (low_cycles < (PULSE_TICKS - 1) * SLOW_CYCLES)
		begin
			$display("Checks failed");
			$fatal(1, "estop_activation pulse ended after only %0d cycles", low_cycles);
		end
		read_check(`RCB_ADDR_ESTOP_ACTIVATION, 32'h8000_0000, "estop_act");
	endtask

	task automatic diag_and_open();
		write_reg(`RCB_ADDR_ESTOP_DIAGNOSTIC, 32'h1234_ABCD);
		read_check(`RCB_ADDR_ESTOP_DIAGNOSTIC, 32'h0000_ABCD, "estop_diag");
		check_value("diag_activation", {31'h0, diag_activation}, 32'h1);
		write_reg(`RCB_ADDR_ESTOP_DIAGNOSTIC, 32'h0000_ABCC);
		check_value("diag_activation", {31'h0, diag_activation}, 32'h0);
		write_reg(`RCB_ADDR_ESTOP_DIAGNOSTIC, 32'h0000_ABCD);
		check_value("diag_activation", {31'h0, diag_activation}, 32'h1);
		write_reg(`RCB_ADDR_ESTOP_ACTIVATION, 32'h0000_0000);
		check_value("diag_activation", {31'h0, diag_activation}, 32'h0);

		write_reg(`RCB_ADDR_ESTOP_OPEN, 32'h0000_0001);
		check_value("estop_open", {31'h0, estop_open}, 32'h1);
		read_check(`RCB_ADDR_ESTOP_OPEN, 32'h0000_0001, "estop_open_reg");
		write_reg(`RCB_ADDR_ESTOP_OPEN, 32'hFFFF_FFFE);
		check_value("estop_open", {31'h0, estop_open}, 32'h0);
		read_check(`RCB_ADDR_ESTOP_OPEN, 32'h0000_0000, "estop_open_reg");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		clk_100m        = 1'b0;
		clk_100k        = 1'b0;
		rst_n_syn       = 1'b0;
		addr            = '0;
		data_mosi       = '0;
		data_mosi_rdy   = 1'b0;
		data_miso_rdy   = 1'b0;
		fpga_buttons    = '0;
		wheel_driver_do = '0;
		// Contacts at rest
		estop_btn1_nc   = 1'b0;
		estop_btn1_no   = 1'b1;
		estop_btn2_nc   = 1'b0;
		estop_btn2_no   = 1'b1;
		repeat (3) @(posedge clk_100m);
		#1;
		rst_n_syn = 1'b1;

		reset_identity();
		masked_writes();
		input_sync_path();
		sticky_flags();
		activation_pulse();
		diag_and_open();

		$display("All checks passed");
		$finish;
	end

endmodule

//--- rcb_registers.sv
/*
 * Register block behind the SPI slave. Top level that ties decode,
 * input sync, sticky flags, control registers, pulse and read mux.
 */
module rcb_registers
	import rcb_pkg::*;
(
	input  logic       clk_100m,
	input  logic       rst_n_syn,
	input  logic       clk_100k,
	input  reg_addr_t  addr,
	input  reg_word_t  data_mosi,
	input  logic       data_mosi_rdy,
	input  logic       data_miso_rdy,
	output reg_word_t  data_miso,
	input  led_byte_t  fpga_buttons,
	input  logic [3:0] wheel_driver_do,
	input  logic       estop_btn1_nc,
	input  logic       estop_btn1_no,
	input  logic       estop_btn2_nc,
	input  logic       estop_btn2_no,
	output logic [3:0] wheel_home_sw,
	output logic [3:0] wheel_reverse_sw,
	output logic [3:0] wheel_forward_sw,
	output led_byte_t  wheel_driver_di,
	output logic       wheel_driver_elo,
	output logic       wheel_driver_rst,
	output logic       wheel_driver_abrt,
	output reg_word_t  fpga_buttons_led_reg,
	output logic       estop_activation,
	output logic       diag_activation,
	output logic       estop_open,
	output led_byte_t  diagnostic_led
);

	logic wr_wheel_out, wr_wheel_elo, wr_wheel_abrt, wr_buttons_led;
	logic wr_estop_act, wr_estop_diag, wr_estop_open, wr_diag_leds;
	logic status_read;
	reg_sel_t rd_sel;

	led_byte_t     buttons_sync;
	logic [3:0]    wheel_do_sync;
	contact_pair_t btn1_sync;
	contact_pair_t btn2_sync;
	logic btn1_no_flag, btn1_nc_flag, btn2_no_flag, btn2_nc_flag;

	reg_word_t wheel_out_reg, wheel_elo_reg, wheel_abrt_reg, buttons_led_reg;
	reg_word_t estop_act_reg, estop_diag_reg, estop_open_reg, diag_led_reg;
	logic      pulse_start_clear;

	rcb_addr_decode rcb_addr_decode_inst (.*);

	rcb_input_sync rcb_input_sync_inst (.*);

	////////////////////////////////////////////////////////////
	// Sticky flags, NO contacts rest high, NC contacts rest low
	////////////////////////////////////////////////////////////
	rcb_estop_sticky #(.NORMAL_LEVEL(1'b1)) sticky_btn1_no_inst (
		.clk_100m(clk_100m), .rst_n_syn(rst_n_syn), .contact(btn1_sync[0]),
		.status_read(status_read), .flag(btn1_no_flag));
	rcb_estop_sticky #(.NORMAL_LEVEL(1'b0)) sticky_btn1_nc_inst (
		.clk_100m(clk_100m), .rst_n_syn(rst_n_syn), .contact(btn1_sync[1]),
		.status_read(status_read), .flag(btn1_nc_flag));
	rcb_estop_sticky #(.NORMAL_LEVEL(1'b1)) sticky_btn2_no_inst (
		.clk_100m(clk_100m), .rst_n_syn(rst_n_syn), .contact(btn2_sync[0]),
		.status_read(status_read), .flag(btn2_no_flag));
	rcb_estop_sticky #(.NORMAL_LEVEL(1'b0)) sticky_btn2_nc_inst (
		.clk_100m(clk_100m), .rst_n_syn(rst_n_syn), .contact(btn2_sync[1]),
		.status_read(status_read), .flag(btn2_nc_flag));

	rcb_control_regs rcb_control_regs_inst (.*);

	rcb_estop_pulse rcb_estop_pulse_inst (
		.clk_100m(clk_100m),
		.rst_n_syn(rst_n_syn),
		.clk_100k(clk_100k),
		.act_bit(estop_act_reg[0]),
		.estop_activation(estop_activation),
		.pulse_start_clear(pulse_start_clear)
	);

	rcb_read_mux rcb_read_mux_inst (.*);

endmodule

//--- rcb_read_mux.sv
/*
 * Read path of the RCB block. Builds the estop status word and
 * returns the word for the selected register, all ones if unmapped.
 */
`include "rcb_params.svh"

module rcb_read_mux
	import rcb_pkg::*;
(
	input  reg_sel_t      rd_sel,
	input  led_byte_t     buttons_sync,
	input  logic [3:0]    wheel_do_sync,
	input  contact_pair_t btn1_sync,
	input  contact_pair_t btn2_sync,
	input  logic          btn1_no_flag,
	input  logic          btn1_nc_flag,
	input  logic          btn2_no_flag,
	input  logic          btn2_nc_flag,
	input  reg_word_t     wheel_out_reg,
	input  reg_word_t     wheel_elo_reg,
	input  reg_word_t     wheel_abrt_reg,
	input  reg_word_t     buttons_led_reg,
	input  reg_word_t     estop_act_reg,
	input  reg_word_t     estop_diag_reg,
	input  reg_word_t     estop_open_reg,
	input  reg_word_t     diag_led_reg,
	output reg_word_t     data_miso
);

	reg_word_t status_word;

	// Per button: synced NO, synced NC, NO flag, NC flag
	assign status_word = {24'h0, btn2_nc_flag, btn2_no_flag, btn2_sync,
		btn1_nc_flag, btn1_no_flag, btn1_sync};

	always_comb
	begin
		case (rd_sel)
			REG_VER:          data_miso = {16'h0, `RCB_FPGA_MAJOR_VER, `RCB_FPGA_REV};
			REG_REV_DATA:     data_miso = {`RCB_REV_YEAR, `RCB_REV_MONTH,
				`RCB_REV_DAY, `RCB_REV_HOUR};
			REG_BUTTONS:      data_miso = {24'h0, buttons_sync};
			REG_WHEEL_OUT:    data_miso = wheel_out_reg;
			REG_WHEEL_ELO:    data_miso = wheel_elo_reg;
			REG_WHEEL_IN:     data_miso = {28'h0, wheel_do_sync};
			REG_WHEEL_ABRT:   data_miso = wheel_abrt_reg;
			REG_BUTTONS_LED:  data_miso = buttons_led_reg;
			REG_ESTOP_STATUS: data_miso = status_word;
			REG_ESTOP_ACT:    data_miso = estop_act_reg;
			REG_ESTOP_DIAG:   data_miso = estop_diag_reg;
			REG_ESTOP_OPEN:   data_miso = estop_open_reg;
			REG_DIAG_LEDS:    data_miso = diag_led_reg;
			default:          data_miso = `RCB_UNMAPPED_READ;
		endcase
	end

endmodule

//--- rcb_estop_pulse.sv
/*
 * Timed low pulse on estop_activation. clk_100k is sampled as data
 * and its rising edges are counted to time the pulse.
 */
`include "rcb_params.svh"

module rcb_estop_pulse
	import rcb_pkg::*;
(
	input  logic clk_100m,
	input  logic rst_n_syn,
	input  logic clk_100k,
	input  logic act_bit,
	output logic estop_activation,
	output logic pulse_start_clear
);

	pulse_state_t state;
	logic         clk_100k_q;
	logic         tick;
	logic [3:0]   tick_cnt;

	// Reset high so a slow clock already high gives no false edge
	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
			clk_100k_q <= 1'b1;
		else
			clk_100k_q <= clk_100k;
	end

	assign tick = clk_100k && !clk_100k_q;

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			state            <= PULSE_IDLE;
			tick_cnt         <= '0;
			estop_activation <= 1'b1;
		end
		else
		begin
			case (state)
				PULSE_IDLE:
				begin
					tick_cnt <= '0;
					if (act_bit)
					begin
						estop_activation <= 1'b0;
						state            <= PULSE_ACTIVE;
					end
				end
				PULSE_ACTIVE:
				begin
					if (tick)
					begin
						if (tick_cnt == `RCB_ESTOP_PULSE_TICKS - 4'd1)
						begin
							estop_activation <= 1'b1;
							tick_cnt         <= '0;
							state            <= PULSE_IDLE;
						end
						else
							tick_cnt <= tick_cnt + 4'd1;
					end
				end
				default:
					state <= PULSE_IDLE;
			endcase
		end
	end

	// First tick of the pulse releases the activation bit
	assign pulse_start_clear = (state == PULSE_ACTIVE) && tick && (tick_cnt == 4'd0);

endmodule

//--- rcb_control_regs.sv
/*
 * Writable registers of the RCB block. Writes are stored with their
 * field masks and the words are sliced onto the output pins.
 */
`include "rcb_params.svh"

module rcb_control_regs
	import rcb_pkg::*;
(
	input  logic       clk_100m,
	input  logic       rst_n_syn,
	input  reg_word_t  data_mosi,
	input  logic       wr_wheel_out,
	input  logic       wr_wheel_elo,
	input  logic       wr_wheel_abrt,
	input  logic       wr_buttons_led,
	input  logic       wr_estop_act,
	input  logic       wr_estop_diag,
	input  logic       wr_estop_open,
	input  logic       wr_diag_leds,
	input  logic       pulse_start_clear,
	output reg_word_t  wheel_out_reg,
	output reg_word_t  wheel_elo_reg,
	output reg_word_t  wheel_abrt_reg,
	output reg_word_t  buttons_led_reg,
	output reg_word_t  estop_act_reg,
	output reg_word_t  estop_diag_reg,
	output reg_word_t  estop_open_reg,
	output reg_word_t  diag_led_reg,
	output logic [3:0] wheel_home_sw,
	output logic [3:0] wheel_reverse_sw,
	output logic [3:0] wheel_forward_sw,
	output led_byte_t  wheel_driver_di,
	output logic       wheel_driver_elo,
	output logic       wheel_driver_rst,
	output logic       wheel_driver_abrt,
	output logic       estop_open,
	output logic       diag_activation,
	output led_byte_t  diagnostic_led,
	output reg_word_t  fpga_buttons_led_reg
);

	wheel_drive_t wheel_drive;

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			wheel_out_reg   <= '0;
			wheel_elo_reg   <= '0;
			wheel_abrt_reg  <= '0;
			buttons_led_reg <= '0;
			estop_act_reg   <= '0;
			estop_diag_reg  <= '0;
			estop_open_reg  <= '0;
			diag_led_reg    <= {24'h0, `RCB_DIAG_LED_RESET};
		end
		else
		begin
			if (wr_wheel_out)
				wheel_out_reg <= data_mosi & 32'h000F_FFFF;
			if (wr_wheel_elo)
				wheel_elo_reg <= data_mosi & 32'h0000_0001;
			if (wr_wheel_abrt)
				wheel_abrt_reg <= data_mosi & 32'h0000_0003;
			// Bits 15, 11, 7 and 3 have no LED behind them
			if (wr_buttons_led)
				buttons_led_reg <= data_mosi & 32'h0000_7777;
			// A write in the clear cycle takes priority
			if (wr_estop_act)
				estop_act_reg <= data_mosi & 32'h8000_0001;
			else if (pulse_start_clear)
				estop_act_reg[0] <= 1'b0;
			if (wr_estop_diag)
				estop_diag_reg <= data_mosi & 32'h0000_FFFF;
			if (wr_estop_open)
				estop_open_reg <= data_mosi & 32'h0000_0001;
			if (wr_diag_leds)
				diag_led_reg <= data_mosi & 32'h0000_00FF;
		end
	end

	////////////////////////////////////////////////////////////
	// Pin slices
	////////////////////////////////////////////////////////////
	assign wheel_drive       = wheel_out_reg[19:0];
	assign wheel_home_sw     = wheel_drive[19:16];
	assign wheel_reverse_sw  = wheel_drive[15:12];
	assign wheel_forward_sw  = wheel_drive[11:8];
	assign wheel_driver_di   = wheel_drive[7:0];
	assign wheel_driver_elo  = wheel_elo_reg[0];
	assign wheel_driver_rst  = wheel_abrt_reg[1];
	assign wheel_driver_abrt = wheel_abrt_reg[0];
	assign estop_open        = estop_open_reg[0];
	assign diagnostic_led    = diag_led_reg[7:0];
	assign fpga_buttons_led_reg = buttons_led_reg;

	// Diagnostic close needs bit 31 and the key together
	assign diag_activation = estop_act_reg[31] &&
		(estop_diag_reg[15:0] == `RCB_ESTOP_DIAG_KEY);

endmodule

//--- rcb_estop_sticky.sv
/*
 * Sticky-until-read flag for one estop contact. Any departure from
 * the rest level is held until the status register has been read
 * and the contact is back at rest.
 */
module rcb_estop_sticky
	import rcb_pkg::*;
#(
	parameter bit NORMAL_LEVEL = 1'b1
)
(
	input  logic clk_100m,
	input  logic rst_n_syn,
	input  logic contact,
	input  logic status_read,
	output logic flag
);

	sticky_state_t state;

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
			state <= STICKY_IDLE;
		else
		begin
			case (state)
				STICKY_IDLE:
				begin
					if (contact != NORMAL_LEVEL)
						state <= STICKY_HELD;
				end
				// Hold regardless of contact until the status read
				STICKY_HELD:
				begin
					if (status_read)
						state <= STICKY_FOLLOW;
				end
				STICKY_FOLLOW:
				begin
					if (contact == NORMAL_LEVEL)
						state <= STICKY_IDLE;
				end
				default:
					state <= STICKY_IDLE;
			endcase
		end
	end

	// Set in both held and follow states
	assign flag = (state != STICKY_IDLE);

endmodule

//--- rcb_input_sync.sv
/*
 * Two-flop synchronizers for the push buttons, the wheel driver
 * feedback and the four estop contacts.
 */
`include "rcb_params.svh"

module rcb_input_sync
	import rcb_pkg::*;
(
	input  logic          clk_100m,
	input  logic          rst_n_syn,
	input  led_byte_t     fpga_buttons,
	input  logic [3:0]    wheel_driver_do,
	input  logic          estop_btn1_nc,
	input  logic          estop_btn1_no,
	input  logic          estop_btn2_nc,
	input  logic          estop_btn2_no,
	output led_byte_t     buttons_sync,
	output logic [3:0]    wheel_do_sync,
	output contact_pair_t btn1_sync,
	output contact_pair_t btn2_sync
);

	// Contacts at rest: NO closed (high), NC open (low)
	localparam logic [7:0] STATUS_RST = `RCB_ESTOP_STATUS_RESET;

	led_byte_t     buttons_meta;
	logic [3:0]    wheel_do_meta;
	contact_pair_t btn1_meta;
	contact_pair_t btn2_meta;

	always_ff @(posedge clk_100m or negedge rst_n_syn)
	begin
		if (!rst_n_syn)
		begin
			buttons_meta  <= '0;
			buttons_sync  <= '0;
			wheel_do_meta <= '0;
			wheel_do_sync <= '0;
			btn1_meta     <= STATUS_RST[1:0];
			btn1_sync     <= STATUS_RST[1:0];
			btn2_meta     <= STATUS_RST[5:4];
			btn2_sync     <= STATUS_RST[5:4];
		end
		else
		begin
			buttons_meta  <= fpga_buttons;
			buttons_sync  <= buttons_meta;
			wheel_do_meta <= wheel_driver_do;
			wheel_do_sync <= wheel_do_meta;
			btn1_meta     <= {estop_btn1_nc, estop_btn1_no};
			btn1_sync     <= btn1_meta;
			btn2_meta     <= {estop_btn2_nc, estop_btn2_no};
			btn2_sync     <= btn2_meta;
		end
	end

endmodule

//--- rcb_addr_decode.sv
/*
 * Address decode for the SPI register block. Maps the address to a
 * register select once and qualifies the write and read strobes.
 */
`include "rcb_params.svh"

module rcb_addr_decode
	import rcb_pkg::*;
(
	input  reg_addr_t addr,
	input  logic      data_mosi_rdy,
	input  logic      data_miso_rdy,
	output logic      wr_wheel_out,
	output logic      wr_wheel_elo,
	output logic      wr_wheel_abrt,
	output logic      wr_buttons_led,
	output logic      wr_estop_act,
	output logic      wr_estop_diag,
	output logic      wr_estop_open,
	output logic      wr_diag_leds,
	output logic      status_read,
	output reg_sel_t  rd_sel
);

	always_comb
	begin
		case (addr)
			`RCB_ADDR_VER:              rd_sel = REG_VER;
			`RCB_ADDR_REV_DATA:         rd_sel = REG_REV_DATA;
			`RCB_ADDR_BUTTONS:          rd_sel = REG_BUTTONS;
			`RCB_ADDR_WHEEL_OUT:        rd_sel = REG_WHEEL_OUT;
			`RCB_ADDR_WHEEL_ELO:        rd_sel = REG_WHEEL_ELO;
			`RCB_ADDR_WHEEL_IN:         rd_sel = REG_WHEEL_IN;
			`RCB_ADDR_WHEEL_ABRT:       rd_sel = REG_WHEEL_ABRT;
			`RCB_ADDR_BUTTONS_LED:      rd_sel = REG_BUTTONS_LED;
			`RCB_ADDR_ESTOP_STATUS:     rd_sel = REG_ESTOP_STATUS;
			`RCB_ADDR_ESTOP_ACTIVATION: rd_sel = REG_ESTOP_ACT;
			`RCB_ADDR_ESTOP_DIAGNOSTIC: rd_sel = REG_ESTOP_DIAG;
			`RCB_ADDR_ESTOP_OPEN:       rd_sel = REG_ESTOP_OPEN;
			`RCB_ADDR_DIAG_LEDS:        rd_sel = REG_DIAG_LEDS;
			default:                    rd_sel = REG_NONE;
		endcase
	end

	// Write enables, one hot since rd_sel holds a single value
	assign wr_wheel_out   = data_mosi_rdy && (rd_sel == REG_WHEEL_OUT);
	assign wr_wheel_elo   = data_mosi_rdy && (rd_sel == REG_WHEEL_ELO);
	assign wr_wheel_abrt  = data_mosi_rdy && (rd_sel == REG_WHEEL_ABRT);
	assign wr_buttons_led = data_mosi_rdy && (rd_sel == REG_BUTTONS_LED);
	assign wr_estop_act   = data_mosi_rdy && (rd_sel == REG_ESTOP_ACT);
	assign wr_estop_diag  = data_mosi_rdy && (rd_sel == REG_ESTOP_DIAG);
	assign wr_estop_open  = data_mosi_rdy && (rd_sel == REG_ESTOP_OPEN);
	assign wr_diag_leds   = data_mosi_rdy && (rd_sel == REG_DIAG_LEDS);

	// Master has taken the status word, sticky flags may release
	assign status_read = data_miso_rdy && (rd_sel == REG_ESTOP_STATUS);

endmodule

//--- rcb_pkg.sv
/*
 * Shared types of the RCB register block: word widths with a
 * meaning, the register select and the state machine encodings.
 */
package rcb_pkg;

	typedef logic [31:0] reg_word_t;
	typedef logic [15:0] reg_addr_t;
	// Home, reverse and forward switches plus DI byte
	typedef logic [19:0] wheel_drive_t;
	typedef logic [7:0]  led_byte_t;
	// Bit 1 is NC, bit 0 is NO
	typedef logic [1:0]  contact_pair_t;

	// One entry per mapped register
	typedef enum logic [3:0] {
		REG_VER,
		REG_REV_DATA,
		REG_BUTTONS,
		REG_WHEEL_OUT,
		REG_WHEEL_ELO,
		REG_WHEEL_IN,
		REG_WHEEL_ABRT,
		REG_BUTTONS_LED,
		REG_ESTOP_STATUS,
		REG_ESTOP_ACT,
		REG_ESTOP_DIAG,
		REG_ESTOP_OPEN,
		REG_DIAG_LEDS,
		REG_NONE
	} reg_sel_t;

	typedef enum logic [1:0] {
		STICKY_IDLE,
		STICKY_HELD,
		STICKY_FOLLOW
	} sticky_state_t;

	typedef enum logic {
		PULSE_IDLE,
		PULSE_ACTIVE
	} pulse_state_t;

endpackage

//--- rcb_params.svh
/*
 * Address map, reset values, version fields and estop constants
 * for the RCB register block. Include where a value is needed.
 */
`ifndef RCB_PARAMS_SVH
`define RCB_PARAMS_SVH

////////////////////////////////////////////////////////////
// Register address map
////////////////////////////////////////////////////////////
`define RCB_ADDR_VER              16'h0000
`define RCB_ADDR_REV_DATA         16'h0001
`define RCB_ADDR_BUTTONS          16'h0003
`define RCB_ADDR_WHEEL_OUT        16'h0008
`define RCB_ADDR_WHEEL_ELO        16'h0009
`define RCB_ADDR_WHEEL_IN         16'h000A
`define RCB_ADDR_WHEEL_ABRT       16'h000B
`define RCB_ADDR_BUTTONS_LED      16'h000D
`define RCB_ADDR_ESTOP_STATUS     16'h000E
`define RCB_ADDR_ESTOP_ACTIVATION 16'h000F
`define RCB_ADDR_ESTOP_DIAGNOSTIC 16'h0010
`define RCB_ADDR_ESTOP_OPEN       16'h0011
`define RCB_ADDR_DIAG_LEDS        16'h0012

////////////////////////////////////////////////////////////
// Version and revision date
////////////////////////////////////////////////////////////
`define RCB_FPGA_MAJOR_VER 8'h01
`define RCB_FPGA_REV       8'h00
`define RCB_REV_YEAR       8'h22
`define RCB_REV_MONTH      8'h10
`define RCB_REV_DAY        8'h19
`define RCB_REV_HOUR       8'h12

////////////////////////////////////////////////////////////
// Estop and reset constants
////////////////////////////////////////////////////////////
// Diagnostic register low half must hold this for diag_activation
`define RCB_ESTOP_DIAG_KEY     16'hABCD
// Activation pulse length in clk_100k periods
`define RCB_ESTOP_PULSE_TICKS  4'd10
`define RCB_DIAG_LED_RESET     8'hFF
`define RCB_ESTOP_STATUS_RESET 8'h11
`define RCB_UNMAPPED_READ      32'hFFFF_FFFF

`endif
